//--- fetchFrontEnd.f
common/fetchPkg.sv
hw/nextPcStage.sv
fetch/fetchStage.sv
fetch/instCache.sv
fetch/branchPredictor.sv
hw/fetchFrontEnd.sv
tests/tbClock.sv
tests/fetchFrontEndTb.sv

//--- tests/fetchFrontEnd_tests.txt
# Columns: command then arguments, PCs in hex, counts in decimal
# test name | lat cycles | stall percent | upd pc taken target | redir pc | wait cycles | expect count
test seqCold
lat 3
stall 0
expect 12
test takenBranch
lat 2
upd 108 1 20c
upd 214 1 100
redir 100
expect 14
test hysteresis
upd 300 1 340
upd 300 1 340
upd 300 0 0
redir 2f8
expect 6
upd 300 0 0
redir 2f8
expect 6
test backPressure
lat 5
stall 40
redir 400
expect 16
stall 50
redir 100
expect 14
test redirectRefill
stall 0
lat 10
redir 600
wait 4
redir 50c
expect 8

//--- tests/fetchFrontEndTb.sv
`timescale 1ns/1ps
/*
 * Testbench for the fetch front end. Runs the command scenario file, models
 * the refill memory, decode back-pressure and execute, and checks the fetched
 * instruction stream in order against a walk of the expected PCs.
 */
module fetchFrontEndTb
    import fetchPkg::*;
();

    logic clk;
    logic arstN;
    logic decodeStall;
    logic redirectValid;
    logic [PC_WIDTH-1:0] redirectPc;
    logic updValid;
    logic [PC_WIDTH-1:0] updPc;
    logic updTaken;
    logic [PC_WIDTH-1:0] updTarget;
    logic memValid;
    logic [FETCH_WIDTH-1:0][INSN_WIDTH-1:0] memData;
    logic memReq;
    logic [PC_WIDTH-1:0] memAddr;
    logic [FETCH_WIDTH-1:0] outValid;
    logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] outPc;
    logic [FETCH_WIDTH-1:0][INSN_WIDTH-1:0] outInsn;
    logic [FETCH_WIDTH-1:0] outPredTaken;
    logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] outPredTarget;

    // Parsed scenario commands
    string opQ[$];
    string nameQ[$];
    logic [31:0] aQ[$];
    logic [31:0] bQ[$];
    logic [31:0] cQ[$];

    // Output stream seen since the last redirect
    logic [PC_WIDTH-1:0] seenPc[$];
    logic [INSN_WIDTH-1:0] seenInsn[$];
    logic seenPredTaken[$];
    logic [PC_WIDTH-1:0] seenPredTarget[$];
    int checkedIdx = 0;
    logic [PC_WIDTH-1:0] modelPc = '0;

    // Trained branches as execute reported them
    logic [PC_WIDTH-1:0] brPc[16];
    logic [PC_WIDTH-1:0] brTarget[16];
    int brCtr[16];
    int brCount = 0;

    int latency = 0;
    int stallPct = 0;
    int limitCycles = 0;
    string testName = "";
    int testCount = 0;
    int testChecks = 0;
    int testErrors = 0;
    int totalChecks = 0;
    int totalErrors = 0;

    tbClock #(.PERIOD_NS(100), .RESET_CYCLES(16)) uClock (.clk, .arstN);

    fetchFrontEnd #(.CACHE_LINES(16), .BTB_ENTRIES(8)) DUT (
        .clk, .arstN, .decodeStall, .redirectValid, .redirectPc,
        .updValid, .updPc, .updTaken, .updTarget, .memValid, .memData,
        .memReq, .memAddr, .outValid, .outPc, .outInsn, .outPredTaken, .outPredTarget
    );

    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Memory content is the word address xor a fixed pattern
    function automatic logic [31:0] wordAt(input logic [PC_WIDTH-1:0] addr);
        return (addr >> 2) ^ 32'hA5A50000;
    endfunction

    // Taken once the counter sits in the upper half, -1 if not taken
    function automatic int takenBranchAt(input logic [PC_WIDTH-1:0] pc);
        for (int i = 0; i < brCount; i++) begin
            if (brPc[i] == pc && brCtr[i] >= 2) return i;
        end
        return -1;
    endfunction

    function automatic logic [PC_WIDTH-1:0] predictNext(input logic [PC_WIDTH-1:0] pc);
        int idx;
        idx = takenBranchAt(pc);
        if (idx >= 0) return brTarget[idx];
        return pc + PC_WIDTH'(INSN_BYTES);
    endfunction

    task automatic trainModel(input logic [PC_WIDTH-1:0] pc, input logic taken,
                              input logic [PC_WIDTH-1:0] target);
        int idx;
        idx = -1;
        for (int i = 0; i < brCount; i++) begin
            if (brPc[i] == pc) idx = i;
        end
        if (idx < 0) begin
            // Only a taken outcome allocates, weakly taken
            if (taken) begin
                brPc[brCount] = pc;
                brTarget[brCount] = target;
                brCtr[brCount] = 2;
                brCount++;
            end
        end else if (taken) begin
            if (brCtr[idx] < 3) brCtr[idx]++;
            brTarget[idx] = target;
        end else if (brCtr[idx] > 0) begin
            brCtr[idx]--;
        end
    endtask

    task automatic driveRedirect(input logic [PC_WIDTH-1:0] pc);
        @(negedge clk);
        redirectValid = 1'b1;
        redirectPc = pc;
        // Old path output is dropped from here on
        seenPc.delete();
        seenInsn.delete();
        seenPredTaken.delete();
        seenPredTarget.delete();
        checkedIdx = 0;
        modelPc = pc;
        @(negedge clk);
        redirectValid = 1'b0;
    endtask

    task automatic driveUpdate(input logic [PC_WIDTH-1:0] pc, input logic taken,
                               input logic [PC_WIDTH-1:0] target);
        @(negedge clk);
        updValid = 1'b1;
        updPc = pc;
        updTaken = taken;
        updTarget = target;
        trainModel(pc, taken, target);
        @(negedge clk);
        updValid = 1'b0;
    endtask

    // Compare the next n output lanes in order, no cycle counting
    task automatic checkStream(input int n);
        logic [PC_WIDTH-1:0] expPc;
        logic [INSN_WIDTH-1:0] expInsn;
        logic expTaken;
        int brIdx;
        while (seenPc.size() < checkedIdx + n) @(posedge clk);
        for (int k = 0; k < n; k++) begin
            expPc = modelPc;
            expInsn = wordAt(modelPc);
            brIdx = takenBranchAt(modelPc);
            expTaken = brIdx >= 0;
            assert (seenPc[checkedIdx] == expPc) else begin
                $display("ERR %s pc #%0d expected %h actual %h",
                         testName, k, expPc, seenPc[checkedIdx]);
                testErrors++;
            end
            assert (seenInsn[checkedIdx] == expInsn) else begin
                $display("ERR %s insn #%0d expected %h actual %h",
                         testName, k, expInsn, seenInsn[checkedIdx]);
                testErrors++;
            end
            assert (seenPredTaken[checkedIdx] == expTaken) else begin
                $display("ERR %s taken #%0d expected %b actual %b",
                         testName, k, expTaken, seenPredTaken[checkedIdx]);
                testErrors++;
            end
            testChecks += 3;
            // Target only means something on a taken prediction
            if (expTaken) begin
                assert (seenPredTarget[checkedIdx] == brTarget[brIdx]) else begin
                    $display("ERR %s target #%0d expected %h actual %h",
                             testName, k, brTarget[brIdx], seenPredTarget[checkedIdx]);
                    testErrors++;
                end
                testChecks++;
            end
            checkedIdx++;
            modelPc = predictNext(modelPc);
        end
    endtask

    task automatic finishTest();
        if (testCount > 0) begin
            $display("test %s: %0d checks, %0d errors", testName, testChecks, testErrors);
            totalChecks += testChecks;
            totalErrors += testErrors;
        end
    endtask

    task automatic runCommand(input int idx);
        string op;
        op = opQ[idx];
        if (op == "test") begin
            finishTest();
            testName = nameQ[idx];
            testChecks = 0;
            testErrors = 0;
            testCount++;
        end else if (op == "lat" || op == "stall") begin
            // Settings change on the rising edge, the drive process reads them on the falling
            @(posedge clk);
            if (op == "lat") latency = int'(aQ[idx]);
            else stallPct = int'(aQ[idx]);
        end else if (op == "upd") begin
            driveUpdate(aQ[idx], bQ[idx][0], cQ[idx]);
        end else if (op == "redir") begin
            driveRedirect(aQ[idx]);
        end else if (op == "wait") begin
            repeat (int'(aQ[idx])) @(negedge clk);
        end else if (op == "expect") begin
            checkStream(int'(aQ[idx]));
        end else begin
            $display("unknown scenario command %s", op);
            totalErrors++;
        end
    endtask

    // Decode back-pressure and the refill memory, one random stream
    initial begin
        logic [31:0] rnd;
        logic pending;
        logic [PC_WIDTH-1:0] reqAddr;
        int waitLeft;
        rnd = 32'h23960b38;
        pending = 1'b0;
        reqAddr = '0;
        waitLeft = 0;
        decodeStall = 1'b0;
        memValid = 1'b0;
        memData = '0;
        forever begin
            @(negedge clk);
            rnd = nextRandom(rnd);
            decodeStall = int'(rnd % 100) < stallPct;
            memValid = 1'b0;
            if (memReq) begin
                pending = 1'b1;
                reqAddr = memAddr;
                rnd = nextRandom(rnd);
                waitLeft = latency + int'(rnd % 4);
            end else if (pending) begin
                if (waitLeft == 0) begin
                    memValid = 1'b1;
                    for (int i = 0; i < FETCH_WIDTH; i++) begin
                        memData[i] = wordAt(reqAddr + PC_WIDTH'(i * INSN_BYTES));
                    end
                    pending = 1'b0;
                end else begin
                    waitLeft--;
                end
            end
        end
    end

    // Collect valid lanes, lowest lane first
    always @(posedge clk) begin
        if (arstN) begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (outValid[i]) begin
                    seenPc.push_back(outPc[i]);
                    seenInsn.push_back(outInsn[i]);
                    seenPredTaken.push_back(outPredTaken[i]);
                    seenPredTarget.push_back(outPredTarget[i]);
                end
            end
        end
    end

    initial begin
        wait (limitCycles > 0);
        repeat (limitCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, fetch stream stopped", limitCycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        string line;
        string word;
        string name;
        int fd;
        int n;
        int totalInsn;
        int totalWait;
        int maxLat;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        redirectValid = 1'b0;
        redirectPc = '0;
        updValid = 1'b0;
        updPc = '0;
        updTaken = 1'b0;
        updTarget = '0;
        totalInsn = 0;
        totalWait = 0;
        maxLat = 0;

        fd = $fopen("tests/fetchFrontEnd_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the scenario file");
            $display("*** FAILED ***");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && $sscanf(line, "%s", word) == 1 && word[0] != "#") begin
                    name = "";
                    a = '0;
                    b = '0;
                    c = '0;
                    if (word == "test") n = $sscanf(line, "%s %s", word, name);
                    else if (word == "upd") n = $sscanf(line, "%s %h %d %h", word, a, b, c);
                    else if (word == "redir") n = $sscanf(line, "%s %h", word, a);
                    else n = $sscanf(line, "%s %d", word, a);
                    opQ.push_back(word);
                    nameQ.push_back(name);
                    aQ.push_back(a);
                    bQ.push_back(b);
                    cQ.push_back(c);
                    if (word == "expect") totalInsn += int'(a);
                    if (word == "wait") totalWait += int'(a);
                    if (word == "lat" && int'(a) > maxLat) maxLat = int'(a);
                end
            end
            $fclose(fd);

            // Every instruction may cost a full refill, doubled for back-pressure
            limitCycles = 16 + totalWait + totalInsn * (maxLat + 9) * 2 + 400;

            repeat (4) @(posedge clk);
            assert (!memReq && outValid == '0) else begin
                $display("memReq or outValid high during reset");
                totalErrors++;
            end
            wait (arstN);

            foreach (opQ[i]) runCommand(i);
            finishTest();

            $display("summary: %0d tests, %0d checks, %0d errors",
                     testCount, totalChecks, totalErrors);
            if (totalErrors == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule

//--- tests/tbClock.sv
`timescale 1ns/1ps
/*
 * Testbench clock and reset source.
 * Free-running clock, reset held low for a number of cycles, released on a falling edge.
 */
module tbClock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release away from the rising edge
    initial begin
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

//--- hw/fetchFrontEnd.sv
`timescale 1ns/1ps
/*
 * Two-wide fetch front end top level.
 * Connects next PC, fetch stage, instruction cache and branch predictor.
 * Execute drives redirect and predictor updates, decode applies the stall.
 */
module fetchFrontEnd
    import fetchPkg::*;
#(
    parameter int CACHE_LINES = 16,
    parameter int BTB_ENTRIES = 8
) (
    input  logic                                   clk,
    input  logic                                   arstN,
    input  logic                                   decodeStall,
    input  logic                                   redirectValid,
    input  logic [PC_WIDTH-1:0]                    redirectPc,
    input  logic                                   updValid,
    input  logic [PC_WIDTH-1:0]                    updPc,
    input  logic                                   updTaken,
    input  logic [PC_WIDTH-1:0]                    updTarget,
    input  logic                                   memValid,
    input  logic [FETCH_WIDTH-1:0][INSN_WIDTH-1:0] memData,
    output logic                                   memReq,
    output logic [PC_WIDTH-1:0]                    memAddr,
    output logic [FETCH_WIDTH-1:0]                 outValid,
    output logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]   outPc,
    output logic [FETCH_WIDTH-1:0][INSN_WIDTH-1:0] outInsn,
    output logic [FETCH_WIDTH-1:0]                 outPredTaken,
    output logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]   outPredTarget
);

    // Next PC to fetch stage
    logic [PC_WIDTH-1:0]    fetchPc;
    logic [FETCH_WIDTH-1:0] fetchLaneValid;

    // Fetch stage back to next PC and predictor
    logic                                 fetchStall;
    logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] pipePc;
    logic [FETCH_WIDTH-1:0]               pipeValid;

    // Predictor results for the fetch-stage lanes
    logic [FETCH_WIDTH-1:0]               predTaken;
    logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] predTarget;

    // Cache lookup
    logic                                   icRe;
    logic [PC_WIDTH-1:0]                    icAddr;
    logic                                   icHit;
    logic [FETCH_WIDTH-1:0][INSN_WIDTH-1:0] icData;

    nextPcStage uNextPc (
        .clk, .arstN, .fetchStall, .redirectValid, .redirectPc,
        .pipePc, .pipeValid, .predTaken, .predTarget,
        .fetchPc, .fetchLaneValid
    );

    fetchStage uFetch (
        .clk, .arstN, .fetchPc, .fetchLaneValid, .decodeStall, .redirectValid,
        .icHit, .icData, .predTaken, .predTarget,
        .icRe, .icAddr, .pipePc, .pipeValid, .fetchStall,
        .outValid, .outPc, .outInsn, .outPredTaken, .outPredTarget
    );

    instCache #(.CACHE_LINES(CACHE_LINES)) uCache (
        .clk, .arstN, .icRe, .icAddr, .memValid, .memData,
        .icHit, .icData, .memReq, .memAddr
    );

    // Predictor looks at the group held in the fetch stage
    branchPredictor #(.BTB_ENTRIES(BTB_ENTRIES)) uPredictor (
        .clk, .arstN, .lookupPc(pipePc),
        .updValid, .updPc, .updTaken, .updTarget,
        .predTaken, .predTarget
    );

endmodule

//--- fetch/branchPredictor.sv
`timescale 1ns/1ps
/*
 * Branch target buffer with a two-bit counter per entry.
 * Every lane looks up its PC combinationally. Execute trains the table
 * through a single update port.
 */
module branchPredictor
    import fetchPkg::*;
#(
    parameter int BTB_ENTRIES = 8
) (
    input  logic                                 clk,
    input  logic                                 arstN,
    input  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] lookupPc,
    input  logic                                 updValid,
    input  logic [PC_WIDTH-1:0]                  updPc,
    input  logic                                 updTaken,
    input  logic [PC_WIDTH-1:0]                  updTarget,
    output logic [FETCH_WIDTH-1:0]               predTaken,
    output logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] predTarget
);

    localparam int INDEX_BITS = $clog2(BTB_ENTRIES);
    localparam int TAG_BITS   = PC_WIDTH - INDEX_BITS - INSN_OFFSET_BITS;

    // Table storage, indexed by word address
    logic [BTB_ENTRIES-1:0] btbValid;
    logic [TAG_BITS-1:0]    btbTag     [BTB_ENTRIES];
    logic [PC_WIDTH-1:0]    btbTarget  [BTB_ENTRIES];
    CounterState            btbCounter [BTB_ENTRIES];

    logic [FETCH_WIDTH-1:0][INDEX_BITS-1:0] lookupIndex;
    logic [INDEX_BITS-1:0]                  updIndex;
    logic [TAG_BITS-1:0]                    updTag;
    logic                                   updHit;
    CounterState                            curCounter;
    CounterState                            nextCounter;

    // Taken needs a tag hit and a counter in the upper half
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            lookupIndex[i] = lookupPc[i][INSN_OFFSET_BITS +: INDEX_BITS];
            predTaken[i]   = btbValid[lookupIndex[i]]
                && (btbTag[lookupIndex[i]] == lookupPc[i][PC_WIDTH-1 -: TAG_BITS])
                && (btbCounter[lookupIndex[i]] inside {weakTaken, strongTaken});
            predTarget[i]  = btbTarget[lookupIndex[i]];
        end
    end

    assign updIndex = updPc[INSN_OFFSET_BITS +: INDEX_BITS];
    assign updTag   = updPc[PC_WIDTH-1 -: TAG_BITS];
    assign updHit   = btbValid[updIndex] && (btbTag[updIndex] == updTag);

    // Saturating step toward the resolved direction
    always_comb begin
        curCounter  = btbCounter[updIndex];
        nextCounter = curCounter;
        if (updTaken && curCounter != strongTaken) begin
            nextCounter = CounterState'(curCounter + 2'd1);
        end else if (!updTaken && curCounter != strongNotTaken) begin
            nextCounter = CounterState'(curCounter - 2'd1);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            btbValid <= '0;
        end else if (updValid && !updHit && updTaken) begin
            btbValid[updIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (updValid) begin
            if (updHit) begin
                btbCounter[updIndex] <= nextCounter;
                if (updTaken) begin
                    btbTarget[updIndex] <= updTarget;
                end
            end else if (updTaken) begin
                // New entries start weakly taken
                btbTag[updIndex]     <= updTag;
                btbTarget[updIndex]  <= updTarget;
                btbCounter[updIndex] <= weakTaken;
            end
        end
    end

endmodule

//--- fetch/instCache.sv
`timescale 1ns/1ps
/*
 * Direct-mapped instruction cache, one fetch group per line.
 * Hit check and read are combinational. A miss starts one refill from the
 * memory port and the line is written when the response arrives.
 */
module instCache
    import fetchPkg::*;
#(
    parameter int CACHE_LINES = 16
) (
    input  logic                                   clk,
    input  logic                                   arstN,
    input  logic                                   icRe,
    input  logic [PC_WIDTH-1:0]                    icAddr,
    input  logic                                   memValid,
    input  logic [FETCH_WIDTH-1:0][INSN_WIDTH-1:0] memData,
    output logic                                   icHit,
    output logic [FETCH_WIDTH-1:0][INSN_WIDTH-1:0] icData,
    output logic                                   memReq,
    output logic [PC_WIDTH-1:0]                    memAddr
);

    localparam int INDEX_BITS = $clog2(CACHE_LINES);
    localparam int TAG_BITS   = PC_WIDTH - INDEX_BITS - LINE_OFFSET_BITS;

    // Line storage
    logic [TAG_BITS-1:0]                    tagArr  [CACHE_LINES];
    logic [FETCH_WIDTH-1:0][INSN_WIDTH-1:0] dataArr [CACHE_LINES];
    logic [CACHE_LINES-1:0]                 validArr;

    FillState              fillState;
    logic [PC_WIDTH-1:0]   fillAddr;
    logic [INDEX_BITS-1:0] rdIndex;
    logic [INDEX_BITS-1:0] fillIndex;
    logic [TAG_BITS-1:0]   rdTag;
    logic [TAG_BITS-1:0]   fillTag;
    logic                  miss;

    assign rdIndex   = icAddr[LINE_OFFSET_BITS +: INDEX_BITS];
    assign rdTag     = icAddr[PC_WIDTH-1 -: TAG_BITS];
    assign fillIndex = fillAddr[LINE_OFFSET_BITS +: INDEX_BITS];
    assign fillTag   = fillAddr[PC_WIDTH-1 -: TAG_BITS];

    assign icHit   = icRe && validArr[rdIndex] && (tagArr[rdIndex] == rdTag);
    assign icData  = dataArr[rdIndex];
    assign miss    = icRe && !icHit;
    assign memAddr = fillAddr;

    // Refill FSM, further misses wait until the line is back
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fillState <= fillIdle;
            memReq    <= 1'b0;
            validArr  <= '0;
        end else begin
            memReq <= 1'b0;
            case (fillState)
                fillIdle: begin
                    if (miss) begin
                        fillState <= fillWait;
                        memReq    <= 1'b1;
                    end
                end
                fillWait: begin
                    if (memValid) begin
                        fillState           <= fillIdle;
                        validArr[fillIndex] <= 1'b1;
                    end
                end
                default: fillState <= fillIdle;
            endcase
        end
    end

    // Refill address is latched since the fetch PC may be redirected
    always_ff @(posedge clk) begin
        if (fillState == fillIdle && miss) begin
            fillAddr <= icAddr & ~PC_WIDTH'(LINE_BYTES - 1);
        end
        if (fillState == fillWait && memValid) begin
            tagArr[fillIndex]  <= fillTag;
            dataArr[fillIndex] <= memData;
        end
    end

    // Memory only answers an outstanding request
    assert property (@(posedge clk) disable iff (!arstN) memValid |-> fillState == fillWait)
        else $error("memory response without a pending refill");

endmodule

//--- fetch/fetchStage.sv
`timescale 1ns/1ps
/*
 * Fetch stage. Holds one fetch group, reads the instruction cache and
 * attaches the branch prediction to each lane. Stalls on a cache miss or
 * decoder back-pressure, and drops lanes after a predicted-taken branch.
 */
module fetchStage
    import fetchPkg::*;
(
    input  logic                                   clk,
    input  logic                                   arstN,
    input  logic [PC_WIDTH-1:0]                    fetchPc,
    input  logic [FETCH_WIDTH-1:0]                 fetchLaneValid,
    input  logic                                   decodeStall,
    input  logic                                   redirectValid,
    input  logic                                   icHit,
    input  logic [FETCH_WIDTH-1:0][INSN_WIDTH-1:0] icData,
    input  logic [FETCH_WIDTH-1:0]                 predTaken,
    input  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]   predTarget,
    output logic                                   icRe,
    output logic [PC_WIDTH-1:0]                    icAddr,
    output logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]   pipePc,
    output logic [FETCH_WIDTH-1:0]                 pipeValid,
    output logic                                   fetchStall,
    output logic [FETCH_WIDTH-1:0]                 outValid,
    output logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]   outPc,
    output logic [FETCH_WIDTH-1:0][INSN_WIDTH-1:0] outInsn,
    output logic [FETCH_WIDTH-1:0]                 outPredTaken,
    output logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0]   outPredTarget
);

    // Group register: line base and per-lane valid
    logic [PC_WIDTH-1:0]    pcReg;
    logic [FETCH_WIDTH-1:0] validReg;

    logic stall;
    logic regStall;
    logic beginStall;
    logic groupValid;
    logic seenTaken;

    // Prediction captured when a stall begins
    logic [FETCH_WIDTH-1:0]               heldTaken;
    logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] heldTarget;
    logic [FETCH_WIDTH-1:0]               effTaken;
    logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] effTarget;
    logic [FETCH_WIDTH-1:0]               isFlushed;

    assign groupValid = |validReg;

    // A miss only counts when there is something to fetch
    assign stall      = decodeStall || (groupValid && !icHit);
    assign beginStall = stall && !regStall;
    assign fetchStall = stall;

    // Whole line is read at once from the line base
    assign icRe   = groupValid;
    assign icAddr = pcReg;

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            pipePc[i] = pcReg + PC_WIDTH'(i * INSN_BYTES);
        end
        pipeValid = validReg;
    end

    always_comb begin
        // Lookup inputs may move under a stall, so use the captured copy
        effTaken  = regStall ? heldTaken : predTaken;
        effTarget = regStall ? heldTarget : predTarget;

        isFlushed = '0;
        seenTaken = 1'b0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            isFlushed[i] = seenTaken && validReg[i];
            if (validReg[i] && effTaken[i]) begin
                seenTaken = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validReg  <= '0;
            regStall  <= 1'b0;
            heldTaken <= '0;
        end else begin
            regStall <= stall;
            if (beginStall) begin
                heldTaken <= predTaken;
            end
            if (redirectValid) begin
                validReg <= '0;
            end else if (!stall) begin
                validReg <= fetchLaneValid;
            end else begin
                // Lanes behind a taken branch go away while held
                validReg <= validReg & ~isFlushed;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pcReg <= fetchPc;
        end
        if (beginStall) begin
            heldTarget <= predTarget;
        end
    end

    // Lanes leave only on the cycle the group moves on
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            outValid[i] = validReg[i] && !stall && !redirectValid && !isFlushed[i];
        end
        outPc         = pipePc;
        outInsn       = icData;
        outPredTaken  = effTaken;
        outPredTarget = effTarget;
    end

    // Valid output needs the cache line present
    assert property (@(posedge clk) disable iff (!arstN) (|outValid) |-> icHit)
        else $error("fetch output valid without a cache hit");

endmodule

//--- hw/nextPcStage.sv
`timescale 1ns/1ps
/*
 * Next-PC stage. Picks the line that the fetch stage loads next.
 * A reset or redirect restart point is held until the fetch stage takes it,
 * otherwise the next line follows the fetch-stage group and its prediction.
 */
module nextPcStage
    import fetchPkg::*;
(
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                fetchStall,
    input  logic                                redirectValid,
    input  logic [PC_WIDTH-1:0]                 redirectPc,
    input  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] pipePc,
    input  logic [FETCH_WIDTH-1:0]              pipeValid,
    input  logic [FETCH_WIDTH-1:0]              predTaken,
    input  logic [FETCH_WIDTH-1:0][PC_WIDTH-1:0] predTarget,
    output logic [PC_WIDTH-1:0]                 fetchPc,
    output logic [FETCH_WIDTH-1:0]              fetchLaneValid
);

    // Pending restart point after reset or redirect
    logic                   restartValid;
    logic [PC_WIDTH-1:0]    restartPc;
    logic [FETCH_WIDTH-1:0] restartLanes;

    // First valid predicted-taken lane of the fetch-stage group
    logic                takenHit;
    logic [PC_WIDTH-1:0] takenPc;

    function automatic logic [PC_WIDTH-1:0] lineBase(input logic [PC_WIDTH-1:0] pc);
        return pc & ~PC_WIDTH'(LINE_BYTES - 1);
    endfunction

    // Lanes below the word offset inside the line are masked
    function automatic logic [FETCH_WIDTH-1:0] laneMask(input logic [PC_WIDTH-1:0] pc);
        logic [FETCH_WIDTH-1:0] mask;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            mask[i] = i >= int'(pc[LINE_OFFSET_BITS-1:INSN_OFFSET_BITS]);
        end
        return mask;
    endfunction

    always_comb begin
        takenHit = 1'b0;
        takenPc  = '0;
        // Walk downward so the lowest taken lane wins
        for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
            if (pipeValid[i] && predTaken[i]) begin
                takenHit = 1'b1;
                takenPc  = predTarget[i];
            end
        end

        if (restartValid) begin
            fetchPc        = restartPc;
            fetchLaneValid = restartLanes;
        end else if (takenHit) begin
            fetchPc        = lineBase(takenPc);
            fetchLaneValid = laneMask(takenPc);
        end else begin
            // Lane 0 PC is always the line base
            fetchPc        = pipePc[0] + PC_WIDTH'(LINE_BYTES);
            fetchLaneValid = '1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            restartValid <= 1'b1;
            restartPc    <= '0;
            restartLanes <= '1;
        end else if (redirectValid) begin
            restartValid <= 1'b1;
            restartPc    <= lineBase(redirectPc);
            restartLanes <= laneMask(redirectPc);
        end else if (!fetchStall) begin
            // Fetch stage took the restart line
            restartValid <= 1'b0;
        end
    end

    // The fetch stage never sits empty without a pending restart
    assert property (@(posedge clk) disable iff (!arstN) fetchLaneValid != '0)
        else $error("next PC offers an empty lane mask");

endmodule

//--- common/fetchPkg.sv
/*
 * Shared definitions for the two-wide fetch front end.
 * Lane count, PC and instruction widths, line geometry and the FSM encodings.
 * Import it with a wildcard in the module header.
 */
package fetchPkg;

    // Fetch group geometry
    localparam int FETCH_WIDTH = 2;
    localparam int PC_WIDTH    = 32;
    localparam int INSN_WIDTH  = 32;
    localparam int INSN_BYTES  = 4;

    // One fetch group is exactly one aligned cache line
    localparam int LINE_BYTES  = FETCH_WIDTH * INSN_BYTES;

    // Byte offset bits of a word and of a line
    localparam int INSN_OFFSET_BITS = $clog2(INSN_BYTES);
    localparam int LINE_OFFSET_BITS = $clog2(LINE_BYTES);

    // Two-bit saturating branch counter
    typedef enum logic [1:0] {
        strongNotTaken,
        weakNotTaken,
        weakTaken,
        strongTaken
    } CounterState;

    // Instruction cache refill FSM
    typedef enum logic {
        fillIdle,
        fillWait
    } FillState;

endpackage
